// ==== Makefile ====
# Verilator build, run and lint for the I/O peripheral block

VERILATOR  ?= verilator
TOP        := gba_io_tb
RTL_TOP    := gba_io_top
FILELIST   := gba_io.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
PASS_TEXT  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== gba_io.f ====
hdl/gba_io_map_pkg.sv
hdl/gba_timer_pkg.sv
hdl/timer_ctrl_if.sv
hdl/irq_ctrl_if.sv
hdl/io_reg_control.sv
hdl/gba_timer.sv
hdl/interrupt_controller.sv
hdl/led_controller.sv
hdl/gba_io_top.sv
verification/gba_io_tb.sv

// ==== hdl/gba_io_map_pkg.sv ====
// I/O page address and data types, register offsets and interrupt bit positions
package gba_io_map_pkg;

    // Bus widths
    localparam int IO_ADDR_W = 12;
    localparam int IO_DATA_W = 16;

    // Byte address within the I/O page
    typedef logic [IO_ADDR_W-1:0] io_addr_t;

    // Halfword of bus data
    typedef logic [IO_DATA_W-1:0] io_data_t;

    // Timer registers, one CNT_L/CNT_H pair per channel
    localparam io_addr_t TM_CNT_L_BASE = 12'h100;
    localparam io_addr_t TM_CNT_H_BASE = 12'h102;
    localparam io_addr_t TM_STRIDE     = 12'h004;

    // Keypad state
    localparam io_addr_t KEYINPUT = 12'h130;

    // Interrupt controller
    localparam io_addr_t IE  = 12'h200;
    localparam io_addr_t IF  = 12'h202;
    localparam io_addr_t IME = 12'h208;

    // Debug LED registers at 0x300, 0x302, 0x304 and 0x306
    localparam io_addr_t LED_REG_BASE = 12'h300;
    localparam int       NUM_LED_REGS = 4;

    // Timer n raises IF bit IRQ_TIMER0_BIT + n
    localparam int IRQ_TIMER0_BIT = 3;

endpackage : gba_io_map_pkg

// ==== hdl/gba_io_top.sv ====
// System peripheral top: register block, timer chain, interrupt controller, LED mux
`timescale 1ns/1ps

module gba_io_top #(
    parameter int num_timers = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  gba_io_map_pkg::io_addr_t bus_addr,
    input  gba_io_map_pkg::io_data_t bus_wdata,
    input  logic                     bus_write,
    input  logic                     bus_read,
    input  logic [15:0]              buttons,
    input  logic [7:0]               sw,
    output gba_io_map_pkg::io_data_t bus_rdata,
    output logic                     nirq,
    output logic [7:0]               ld
);

    timer_ctrl_if tmr [num_timers] ();
    irq_ctrl_if   irq ();

    gba_io_map_pkg::io_data_t led_regs [gba_io_map_pkg::NUM_LED_REGS];

    // Bit 0 is the unused cascade input of channel 0
    logic [num_timers:0]   ovf_chain;
    logic [num_timers-1:0] timer_irq_enable;

    assign ovf_chain[0] = 1'b0;

    io_reg_control #(
        .num_timers (num_timers)
    ) u_io_reg_control (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_write (bus_write),
        .bus_read  (bus_read),
        .buttons   (buttons),
        .bus_rdata (bus_rdata),
        .led_regs  (led_regs),
        .tmr       (tmr),
        .irq       (irq)
    );

    for (genvar i = 0; i < num_timers; i++) begin : g_timer
        gba_timer u_gba_timer (
            .clock      (clock),
            .reset      (reset),
            .cascade_in (ovf_chain[i]),
            .ctl        (tmr[i])
        );

        assign ovf_chain[i+1]      = tmr[i].overflow;
        assign timer_irq_enable[i] = tmr[i].control.irq_enable;
    end

    interrupt_controller #(
        .num_timers (num_timers)
    ) u_interrupt_controller (
        .clock            (clock),
        .reset            (reset),
        .timer_overflow   (ovf_chain[num_timers:1]),
        .timer_irq_enable (timer_irq_enable),
        .irq              (irq),
        .nirq             (nirq)
    );

    led_controller u_led_controller (
        .sw       (sw),
        .led_regs (led_regs),
        .buttons  (buttons),
        .ld       (ld)
    );

endmodule : gba_io_top

// ==== hdl/gba_timer.sv ====
// Timer channel with prescaler, cascade tick input, reload and overflow pulse
`timescale 1ns/1ps

module gba_timer (
    input  logic        clock,
    input  logic        reset,
    input  logic        cascade_in,
    timer_ctrl_if.timer ctl
);

    logic [gba_timer_pkg::PRESCALE_W-1:0] presc_q;
    gba_io_map_pkg::io_data_t             count_q;
    logic                                 running;
    logic                                 presc_tick;
    logic                                 tick;

    assign running = ctl.control.start;

    // Prescaler wraps at the selected divider period
    assign presc_tick = (presc_q == gba_timer_pkg::PRESCALE_MAX[ctl.control.prescale]);

    assign tick = ctl.control.cascade ? cascade_in : presc_tick;

    // Count is still stale during the load cycle
    assign ctl.overflow = running && !ctl.load && tick && (count_q == 16'hFFFF);

    assign ctl.count = count_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            presc_q <= '0;
            count_q <= '0;
        end else if (ctl.load) begin
            presc_q <= '0;
            count_q <= ctl.reload;
        end else if (running) begin
            if (!ctl.control.cascade) begin
                if (presc_tick) begin
                    presc_q <= '0;
                end else begin
                    presc_q <= presc_q + 1'b1;
                end
            end
            if (ctl.overflow) begin
                count_q <= ctl.reload;
            end else if (tick) begin
                count_q <= count_q + 16'd1;
            end
        end
    end

endmodule : gba_timer

// ==== hdl/gba_timer_pkg.sv ====
// Timer control halfword layout, prescaler encoding and prescale divider values
package gba_timer_pkg;

    // Width of the prescale counter, enough for divide-by-1024
    localparam int PRESCALE_W = 10;

    // Prescaler selection in CNT_H bits 1:0
    typedef enum logic [1:0] {
        PRESCALE_1    = 2'd0,
        PRESCALE_64   = 2'd1,
        PRESCALE_256  = 2'd2,
        PRESCALE_1024 = 2'd3
    } prescale_e;

    // CNT_H layout, reserved fields always read as zero
    typedef struct packed {
        logic [7:0] reserved_hi;
        logic       start;
        logic       irq_enable;
        logic [2:0] reserved_lo;
        logic       cascade;
        prescale_e  prescale;
    } timer_cnt_h_t;

    // Last prescale count before a tick, indexed by prescale_e
    localparam logic [3:0][PRESCALE_W-1:0] PRESCALE_MAX = {
        10'd1023,
        10'd255,
        10'd63,
        10'd0
    };

endpackage : gba_timer_pkg

// ==== hdl/interrupt_controller.sv ====
// Interrupt controller: IF register, acknowledge clearing and registered nirq
`timescale 1ns/1ps

module interrupt_controller #(
    parameter int num_timers = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [num_timers-1:0] timer_overflow,
    input  logic [num_timers-1:0] timer_irq_enable,
    irq_ctrl_if.intc              irq,
    output logic                  nirq
);

    gba_io_map_pkg::io_data_t if_q;
    gba_io_map_pkg::io_data_t set_bits;
    gba_io_map_pkg::io_data_t clr_bits;

    always_comb begin
        set_bits = '0;
        for (int i = 0; i < num_timers; i++) begin
            set_bits[gba_io_map_pkg::IRQ_TIMER0_BIT + i] = timer_overflow[i]
                                                          && timer_irq_enable[i];
        end
    end

    assign clr_bits = irq.ack_write ? irq.ack_data : '0;

    // New requests win over a same-cycle acknowledge
    always_ff @(posedge clock) begin
        if (reset) begin
            if_q <= '0;
        end else begin
            if_q <= (if_q & ~clr_bits) | set_bits;
        end
    end

    assign irq.flags = if_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            nirq <= 1'b1;
        end else begin
            nirq <= !(irq.ime && |(irq.ie & if_q));
        end
    end

endmodule : interrupt_controller

// ==== hdl/io_reg_control.sv ====
// I/O register block: address decode, register storage, load and ack strobes, read mux
`timescale 1ns/1ps

module io_reg_control #(
    parameter int num_timers = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  gba_io_map_pkg::io_addr_t  bus_addr,
    input  gba_io_map_pkg::io_data_t  bus_wdata,
    input  logic                      bus_write,
    input  logic                      bus_read,
    input  logic [15:0]               buttons,
    output gba_io_map_pkg::io_data_t  bus_rdata,
    output gba_io_map_pkg::io_data_t  led_regs [gba_io_map_pkg::NUM_LED_REGS],
    timer_ctrl_if.ctrl                tmr [num_timers],
    irq_ctrl_if.ctrl                  irq
);

    gba_io_map_pkg::io_data_t     reload_q  [num_timers];
    gba_timer_pkg::timer_cnt_h_t  control_q [num_timers];
    gba_io_map_pkg::io_data_t     count_in  [num_timers];
    logic [num_timers-1:0]        load_q;
    gba_io_map_pkg::io_data_t     ie_q;
    logic                         ime_q;
    gba_timer_pkg::timer_cnt_h_t  wr_ctl;
    gba_io_map_pkg::io_data_t     rdata_next;
    logic                         led_hit;

    for (genvar i = 0; i < num_timers; i++) begin : g_tmr
        assign tmr[i].reload  = reload_q[i];
        assign tmr[i].control = control_q[i];
        assign tmr[i].load    = load_q[i];
        assign count_in[i]    = tmr[i].count;
    end

    assign irq.ie        = ie_q;
    assign irq.ime       = ime_q;
    // Writing 1 to an IF bit clears it at the write edge
    assign irq.ack_write = bus_write && (bus_addr == gba_io_map_pkg::IF);
    assign irq.ack_data  = bus_wdata;

    assign led_hit = (bus_addr[11:3] == gba_io_map_pkg::LED_REG_BASE[11:3]);

    // Reserved CNT_H bits are dropped on write
    always_comb begin
        wr_ctl            = '0;
        wr_ctl.prescale   = gba_timer_pkg::prescale_e'(bus_wdata[1:0]);
        wr_ctl.cascade    = bus_wdata[2];
        wr_ctl.irq_enable = bus_wdata[6];
        wr_ctl.start      = bus_wdata[7];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_timers; i++) begin
                reload_q[i]  <= '0;
                control_q[i] <= '0;
            end
            for (int j = 0; j < gba_io_map_pkg::NUM_LED_REGS; j++) begin
                led_regs[j] <= '0;
            end
            load_q <= '0;
            ie_q   <= '0;
            ime_q  <= 1'b0;
        end else begin
            load_q <= '0;
            if (bus_write) begin
                for (int i = 0; i < num_timers; i++) begin
                    if (bus_addr == gba_io_map_pkg::io_addr_t'(gba_io_map_pkg::TM_CNT_L_BASE
                            + gba_io_map_pkg::TM_STRIDE * i)) begin
                        reload_q[i] <= bus_wdata;
                    end
                    if (bus_addr == gba_io_map_pkg::io_addr_t'(gba_io_map_pkg::TM_CNT_H_BASE
                            + gba_io_map_pkg::TM_STRIDE * i)) begin
                        control_q[i] <= wr_ctl;
                        // Channel 0 has nothing to cascade from
                        if (i == 0) begin
                            control_q[i].cascade <= 1'b0;
                        end
                        load_q[i] <= wr_ctl.start && !control_q[i].start;
                    end
                end
                if (bus_addr == gba_io_map_pkg::IE) begin
                    ie_q <= bus_wdata;
                end
                if (bus_addr == gba_io_map_pkg::IME) begin
                    ime_q <= bus_wdata[0];
                end
                if (led_hit) begin
                    led_regs[bus_addr[2:1]] <= bus_wdata;
                end
            end
        end
    end

    always_comb begin
        rdata_next = '0;
        for (int i = 0; i < num_timers; i++) begin
            // CNT_L reads back the live count, not the reload value
            if (bus_addr == gba_io_map_pkg::io_addr_t'(gba_io_map_pkg::TM_CNT_L_BASE
                    + gba_io_map_pkg::TM_STRIDE * i)) begin
                rdata_next = count_in[i];
            end
            if (bus_addr == gba_io_map_pkg::io_addr_t'(gba_io_map_pkg::TM_CNT_H_BASE
                    + gba_io_map_pkg::TM_STRIDE * i)) begin
                rdata_next = gba_io_map_pkg::io_data_t'(control_q[i]);
            end
        end
        if (bus_addr == gba_io_map_pkg::KEYINPUT) rdata_next = buttons;
        if (bus_addr == gba_io_map_pkg::IE) rdata_next = ie_q;
        if (bus_addr == gba_io_map_pkg::IF) rdata_next = irq.flags;
        if (bus_addr == gba_io_map_pkg::IME) rdata_next = {15'd0, ime_q};
        if (led_hit) rdata_next = led_regs[bus_addr[2:1]];
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            bus_rdata <= '0;
        end else if (bus_read) begin
            bus_rdata <= rdata_next;
        end
    end

endmodule : io_reg_control

// ==== hdl/irq_ctrl_if.sv ====
// Interface between the register block and the interrupt controller
`timescale 1ns/1ps

interface irq_ctrl_if;

    // Enables and acknowledge writes from the register block
    gba_io_map_pkg::io_data_t ie;
    logic                     ime;
    logic                     ack_write;
    gba_io_map_pkg::io_data_t ack_data;

    // Current IF value
    gba_io_map_pkg::io_data_t flags;

    modport ctrl (
        output ie, ime, ack_write, ack_data,
        input  flags
    );

    modport intc (
        input  ie, ime, ack_write, ack_data,
        output flags
    );

endinterface : irq_ctrl_if

// ==== hdl/led_controller.sv ====
// Debug LED multiplexer over the LED registers and the inverted buttons
`timescale 1ns/1ps

module led_controller (
    input  logic [7:0]               sw,
    input  gba_io_map_pkg::io_data_t led_regs [gba_io_map_pkg::NUM_LED_REGS],
    input  logic [15:0]              buttons,
    output logic [7:0]               ld
);

    always_comb begin
        if (sw < 8'd8) begin
            // Byte sw of the LED registers, low byte first
            if (sw[0]) begin
                ld = led_regs[sw[2:1]][15:8];
            end else begin
                ld = led_regs[sw[2:1]][7:0];
            end
        end else if (sw[7]) begin
            ld = ~buttons[15:8];
        end else begin
            ld = ~buttons[7:0];
        end
    end

endmodule : led_controller

// ==== hdl/timer_ctrl_if.sv ====
// Interface between the register block and one timer channel
`timescale 1ns/1ps

interface timer_ctrl_if;

    // Configuration from the register block
    gba_io_map_pkg::io_data_t     reload;
    gba_timer_pkg::timer_cnt_h_t  control;
    logic                         load;

    // Status from the timer
    gba_io_map_pkg::io_data_t     count;
    logic                         overflow;

    modport ctrl (
        output reload, control, load,
        input  count
    );

    modport timer (
        input  reload, control, load,
        output count, overflow
    );

endinterface : timer_ctrl_if

// ==== verification/gba_io_tb.sv ====
// Testbench for the I/O peripheral top with clock, reset, bus tasks, tests, checks and report
`timescale 1ns/1ps

module gba_io_tb;

    localparam logic [11:0] KEYINPUT_ADDR = 12'h130;
    localparam logic [11:0] IE_ADDR       = 12'h200;
    localparam logic [11:0] IF_ADDR       = 12'h202;
    localparam logic [11:0] IME_ADDR      = 12'h208;
    localparam logic [11:0] LED_BASE      = 12'h300;
    localparam int          RESET_CYCLES  = 16;
    localparam int          DIV64         = 64;
    // Two divide-by-64 timer periods dominate the run time
    localparam int          TIMEOUT_CYCLES = 4 * (RESET_CYCLES + 2 * DIV64 + 200);

    logic        clock;
    logic        reset;
    logic [11:0] bus_addr;
    logic [15:0] bus_wdata;
    logic        bus_write;
    logic        bus_read;
    logic [15:0] buttons;
    logic [7:0]  sw;
    logic [15:0] bus_rdata;
    logic        nirq;
    logic [7:0]  ld;

    integer      seed = 32'h7d69_6b32;
    int          errors = 0;
    int          assert_errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycle_count = 0;
    logic [15:0] led_model [4];

    gba_io_top #(
        .num_timers (4)
    ) u_gba_io_top (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_write (bus_write),
        .bus_read  (bus_read),
        .buttons   (buttons),
        .sw        (sw),
        .bus_rdata (bus_rdata),
        .nirq      (nirq),
        .ld        (ld)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Read data only moves on the edge that samples a read strobe
    rdata_hold: assert property (@(posedge clock) disable iff (reset)
        !$past(bus_read) |-> $stable(bus_rdata))
        else begin
            $display("bus_rdata changed without a read strobe at cycle %0d", cycle_count);
            assert_errors++;
        end

    function automatic logic [11:0] timer_addr(input int n, input logic high);
        return 12'h100 + 12'(4 * n) + (high ? 12'h002 : 12'h000);
    endfunction

    // CNT_H has start in bit 7, irq enable in bit 6, cascade in bit 2, prescale in bits 1:0
    function automatic logic [15:0] cnt_h_value(input logic [1:0] prescale,
                                                input logic cascade, input logic start_irq);
        return {8'd0, start_irq, start_irq, 3'd0, cascade, prescale};
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [15:0] data);
        bus_addr  = addr;
        bus_wdata = data;
        bus_write = 1'b1;
        next_cycle();
        bus_write = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [15:0] data);
        bus_addr = addr;
        bus_read = 1'b1;
        next_cycle();
        bus_read = 1'b0;
        data     = bus_rdata;
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - errors_at_start);
    endtask

    initial begin
        logic [15:0] rd;
        logic [31:0] rnd;
        logic [7:0]  exp_byte;
        int          errors_at_start;
        int          polls;
        int          ticks;

        reset     = 1'b1;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_write = 1'b0;
        bus_read  = 1'b0;
        buttons   = '0;
        sw        = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;

        errors_at_start = errors;
        check_value("reset_nirq", 16'h0001, {15'd0, nirq});
        check_value("reset_rdata", 16'h0000, bus_rdata);
        read_reg(IF_ADDR, rd);
        check_value("reset_if", 16'h0000, rd);
        end_test("reset_state", errors_at_start);

        errors_at_start = errors;
        rnd = $random(seed);
        buttons = rnd[15:0];
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            led_model[i] = rnd[15:0];
            write_reg(LED_BASE + 12'(2 * i), led_model[i]);
        end
        rnd = $random(seed);
        write_reg(IE_ADDR, rnd[15:0]);
        write_reg(IME_ADDR, rnd[31:16]);
        for (int i = 0; i < 4; i++) begin
            read_reg(LED_BASE + 12'(2 * i), rd);
            check_value("led_readback", led_model[i], rd);
        end
        read_reg(IE_ADDR, rd);
        check_value("ie_readback", rnd[15:0], rd);
        // Only bit 0 of IME is stored
        read_reg(IME_ADDR, rd);
        check_value("ime_readback", {15'd0, rnd[16]}, rd);
        read_reg(KEYINPUT_ADDR, rd);
        check_value("keyinput", buttons, rd);
        read_reg(12'h040, rd);
        check_value("unmapped_040", 16'h0000, rd);
        read_reg(12'h204, rd);
        check_value("unmapped_204", 16'h0000, rd);
        end_test("register_readback", errors_at_start);

        errors_at_start = errors;
        write_reg(IE_ADDR, 16'h0008);
        write_reg(IME_ADDR, 16'h0001);
        write_reg(timer_addr(0, 1'b0), 16'hFFF0);
        write_reg(timer_addr(0, 1'b1), cnt_h_value(2'd0, 1'b0, 1'b1));
        // Load edge, then one tick per cycle, then IF set, then nirq
        ticks = 32'h10000 - 32'hFFF0;
        repeat (ticks + 1) @(posedge clock);
        #2;
        check_value("nirq_before_irq", 16'h0001, {15'd0, nirq});
        next_cycle();
        check_value("nirq_after_irq", 16'h0000, {15'd0, nirq});
        read_reg(timer_addr(0, 1'b0), rd);
        checks++;
        assert (rd >= 16'hFFF0) else begin
            $display("FAILED tm0_count: expected >= fff0, actual %h", rd);
            errors++;
        end
        write_reg(timer_addr(0, 1'b1), 16'h0000);
        end_test("timer_overflow", errors_at_start);

        errors_at_start = errors;
        write_reg(timer_addr(2, 1'b0), 16'hFFFF);
        write_reg(timer_addr(2, 1'b1), cnt_h_value(2'd0, 1'b1, 1'b1));
        write_reg(timer_addr(1, 1'b0), 16'hFFFE);
        write_reg(timer_addr(1, 1'b1), cnt_h_value(2'd1, 1'b0, 1'b1));
        polls = 0;
        rd = '0;
        while (!rd[4] && polls < 4 * DIV64) begin
            read_reg(IF_ADDR, rd);
            polls++;
            checks++;
            // Timer 2 overflows on the first timer 1 overflow
            assert (rd[5] === rd[4]) else begin
                $display("FAILED if_cascade: expected %b, actual %b", rd[4], rd[5]);
                errors++;
            end
        end
        // Load edge, two prescaled ticks, IF register ahead of the read register
        check_value("tm1_latency", 16'(1 + 2 * DIV64 + 1), 16'(polls));
        check_value("if_timers", 16'h0038, rd & 16'h0038);
        write_reg(timer_addr(1, 1'b1), 16'h0000);
        write_reg(timer_addr(2, 1'b1), 16'h0000);
        end_test("prescale_cascade", errors_at_start);

        errors_at_start = errors;
        check_value("nirq_pending", 16'h0000, {15'd0, nirq});
        write_reg(IF_ADDR, 16'h0008);
        check_value("nirq_ack_hold", 16'h0000, {15'd0, nirq});
        next_cycle();
        check_value("nirq_acked", 16'h0001, {15'd0, nirq});
        read_reg(IF_ADDR, rd);
        check_value("if_after_ack", 16'h0030, rd);
        repeat (2) next_cycle();
        check_value("nirq_ie_masked", 16'h0001, {15'd0, nirq});
        write_reg(IME_ADDR, 16'h0000);
        write_reg(IE_ADDR, 16'h0030);
        repeat (2) next_cycle();
        check_value("nirq_ime_masked", 16'h0001, {15'd0, nirq});
        write_reg(IME_ADDR, 16'h0001);
        check_value("nirq_ime_hold", 16'h0001, {15'd0, nirq});
        next_cycle();
        check_value("nirq_ime_set", 16'h0000, {15'd0, nirq});
        write_reg(IF_ADDR, 16'h0030);
        next_cycle();
        check_value("nirq_all_acked", 16'h0001, {15'd0, nirq});
        read_reg(IF_ADDR, rd);
        check_value("if_cleared", 16'h0000, rd);
        end_test("ack_and_masking", errors_at_start);

        errors_at_start = errors;
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            sw = {5'd0, rnd[2:0]};
            next_cycle();
            exp_byte = rnd[0] ? led_model[rnd[2:1]][15:8] : led_model[rnd[2:1]][7:0];
            check_value("ld_led_byte", {8'd0, exp_byte}, {8'd0, ld});
        end
        sw = 8'h80;
        next_cycle();
        check_value("ld_buttons_high", {8'd0, ~buttons[15:8]}, {8'd0, ld});
        sw = 8'h10;
        next_cycle();
        check_value("ld_buttons_low", {8'd0, ~buttons[7:0]}, {8'd0, ld});
        end_test("led_mux", errors_at_start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks,
                 errors + assert_errors);
        if (errors + assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
        end
        $display("Timeout: tests still running after %0d cycles", cycle_count);
        $display("Verification failed");
        $finish;
    end

endmodule : gba_io_tb
